//--- verilog/scope_pkg.sv
////////////////////////////////////////////////////////////
// strip-chart scope shared definitions
// sample, trace, raster and column types
// channel colors
////////////////////////////////////////////////////////////

`default_nettype none

package scope_pkg;

	// raw ADC sample and its displayed height (top 8 bits)
	typedef logic [11:0] adc_value_t;
	typedef logic [7:0]  trace_value_t;

	// raster counts, buffer addressing and pixel color
	typedef logic [9:0]  coord_t;
	typedef logic [8:0]  col_addr_t;
	typedef logic [23:0] rgb_t;

	// channel order is A0, A1, B0, B1
	localparam int NUM_CHANNELS = 4;

	typedef struct packed {
		adc_value_t a0;
		adc_value_t a1;
		adc_value_t b0;
		adc_value_t b1;
	} adc_sample_t;

	// one scope column, min and max height per channel
	typedef struct packed {
		trace_value_t a0_min;
		trace_value_t a0_max;
		trace_value_t a1_min;
		trace_value_t a1_max;
		trace_value_t b0_min;
		trace_value_t b0_max;
		trace_value_t b1_min;
		trace_value_t b1_max;
	} column_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   frame_end;
	} raster_t;

	// white, red, green, blue
	localparam rgb_t COLOR_A0 = 24'hffffff;
	localparam rgb_t COLOR_A1 = 24'hff0000;
	localparam rgb_t COLOR_B0 = 24'h00ff00;
	localparam rgb_t COLOR_B1 = 24'h0000ff;

endpackage

`default_nettype wire

//--- verilog/raster_counter.sv
////////////////////////////////////////////////////////////
// raster counter
// pixel and line counts from blank, frame end from vsync
////////////////////////////////////////////////////////////

`default_nettype none

module raster_counter (
	input  logic               clk,
	input  logic               reset,
	input  logic               blank,
	input  logic               vsync,
	output scope_pkg::raster_t raster
);

	logic blank_d;
	logic vsync_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d <= 1'b0;
			vsync_d <= 1'b0;
			raster  <= '0;
		end else begin
			blank_d <= blank;
			vsync_d <= vsync;
			// first active pixel after blank gets x of 0
			raster.x <= (blank || blank_d) ? '0 : raster.x + 1'b1;
			// new line on each rising edge of blank
			if (vsync) begin
				raster.y <= '0;
			end else if (blank && !blank_d) begin
				raster.y <= raster.y + 1'b1;
			end
			raster.active <= !blank;
			// single frame marker on vsync falling
			raster.frame_end <= vsync_d && !vsync;
		end
	end

endmodule

`default_nettype wire

//--- verilog/minmax_accumulator.sv
////////////////////////////////////////////////////////////
// min/max accumulator
// running per-channel min and max over N_FRAMES frames
// column register and commit pulse
////////////////////////////////////////////////////////////

`default_nettype none

module minmax_accumulator #(
	parameter int N_FRAMES = 3
) (
	input  logic                   clk,
	input  logic                   reset,
	input  scope_pkg::adc_sample_t sample,
	input  logic                   sample_valid,
	input  scope_pkg::raster_t     raster,
	output scope_pkg::column_t     column,
	output logic                   commit
);

	import scope_pkg::*;

	localparam int CNT_W = (N_FRAMES > 1) ? $clog2(N_FRAMES) : 1;

	adc_value_t       smp     [NUM_CHANNELS];
	adc_value_t       run_min [NUM_CHANNELS];
	adc_value_t       run_max [NUM_CHANNELS];
	logic [CNT_W-1:0] frame_cnt;
	logic             wrap;

	assign smp  = '{sample.a0, sample.a1, sample.b0, sample.b1};
	assign wrap = raster.frame_end && (frame_cnt == CNT_W'(N_FRAMES - 1));

	////////////////////////////////////////////////////////////
	// frame count and running extremes

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
			commit    <= 1'b0;
			for (int k = 0; k < NUM_CHANNELS; k++) begin
				run_min[k] <= '1;
				run_max[k] <= '0;
			end
		end else begin
			commit <= wrap;
			if (raster.frame_end) begin
				frame_cnt <= wrap ? '0 : frame_cnt + 1'b1;
			end
			for (int k = 0; k < NUM_CHANNELS; k++) begin
				if (wrap) begin
					// restart; an empty span keeps min above max
					run_min[k] <= sample_valid ? smp[k] : '1;
					run_max[k] <= sample_valid ? smp[k] : '0;
				end else if (sample_valid) begin
					if (smp[k] < run_min[k]) run_min[k] <= smp[k];
					if (smp[k] > run_max[k]) run_max[k] <= smp[k];
				end
			end
		end
	end

	// hold the finished span, truncated to display height
	always_ff @(posedge clk) begin
		if (wrap) begin
			column.a0_min <= run_min[0][11:4];
			column.a0_max <= run_max[0][11:4];
			column.a1_min <= run_min[1][11:4];
			column.a1_max <= run_max[1][11:4];
			column.b0_min <= run_min[2][11:4];
			column.b0_max <= run_max[2][11:4];
			column.b1_min <= run_min[3][11:4];
			column.b1_max <= run_max[3][11:4];
		end
	end

endmodule

`default_nettype wire

//--- verilog/capture_buffer.sv
////////////////////////////////////////////////////////////
// scrolling capture buffer
// column memory, write pointer with halt, read addressing
////////////////////////////////////////////////////////////

`default_nettype none

module capture_buffer #(
	parameter int H_START = 450,
	parameter int H_END   = 750
) (
	input  logic               clk,
	input  logic               reset,
	input  scope_pkg::column_t column,
	input  logic               commit,
	input  logic               halt,
	input  scope_pkg::coord_t  x,
	output scope_pkg::column_t rd_column
);

	import scope_pkg::*;

	localparam int SPAN  = H_END - H_START;
	localparam int DEPTH = 1 << $bits(col_addr_t);

	column_t   mem [DEPTH];
	col_addr_t wr_ptr;
	col_addr_t rd_addr;
	coord_t    fill_cnt;
	coord_t    age;
	logic      wr_en;
	logic      rd_valid;
	column_t   empty_col;

	assign wr_en = commit && !halt;

	// the newest column is one below the write pointer and sits at x == H_END
	assign rd_addr = wr_ptr - col_addr_t'(SPAN + 1) + col_addr_t'(x - coord_t'(H_START));

	// columns not yet written since reset read back as empty
	assign age      = coord_t'(H_END) - x;
	assign rd_valid = age < fill_cnt;
	assign empty_col = '{'1, '0, '1, '0, '1, '0, '1, '0};

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= col_addr_t'(SPAN);
			fill_cnt <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
			if (fill_cnt <= coord_t'(SPAN)) fill_cnt <= fill_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= column;
		rd_column <= rd_valid ? mem[rd_addr] : empty_col;
	end

endmodule

`default_nettype wire

//--- verilog/pixel_render.sv
////////////////////////////////////////////////////////////
// pixel renderer
// band, grid and window tests, color priority
////////////////////////////////////////////////////////////

`default_nettype none

module pixel_render #(
	parameter int              V_START  = 240,
	parameter int              V_HEIGHT = 192,
	parameter int              H_START  = 450,
	parameter int              H_END    = 750,
	parameter scope_pkg::rgb_t GD_COLOR = 24'h32006a,
	parameter scope_pkg::rgb_t BG_COLOR = 24'h1d1d1d
) (
	input  logic               clk,
	input  logic               reset,
	input  scope_pkg::raster_t raster,
	input  scope_pkg::column_t rd_column,
	output logic [7:0]         red,
	output logic [7:0]         green,
	output logic [7:0]         blue
);

	import scope_pkg::*;

	// band offsets stack the four traces in the window
	localparam int OFFSET [NUM_CHANNELS] = '{48, 16, -16, -48};

	raster_t                 raster_d;
	coord_t                  row;
	logic                    in_win;
	trace_value_t            lo [NUM_CHANNELS];
	trace_value_t            hi [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] hit;
	logic [NUM_CHANNELS-1:0] pel_ch;
	logic                    pel_grid;
	logic                    pel_win;
	rgb_t                    color;

	function automatic logic band_hit(trace_value_t lo_v, trace_value_t hi_v,
			coord_t r, int offset);
		int h;
		h = int'(r) + offset;
		return (h >= int'(lo_v)) && (h <= int'(hi_v));
	endfunction

	assign lo = '{rd_column.a0_min, rd_column.a1_min, rd_column.b0_min, rd_column.b1_min};
	assign hi = '{rd_column.a0_max, rd_column.a1_max, rd_column.b0_max, rd_column.b1_max};

	assign row    = raster_d.y - coord_t'(V_START);
	assign in_win = raster_d.active &&
		raster_d.y >= coord_t'(V_START) && raster_d.y < coord_t'(V_START + V_HEIGHT) &&
		raster_d.x >= coord_t'(H_START) && raster_d.x <= coord_t'(H_END);

	always_comb begin
		for (int k = 0; k < NUM_CHANNELS; k++) hit[k] = band_hit(lo[k], hi[k], row, OFFSET[k]);
	end

	////////////////////////////////////////////////////////////
	// raster lines up with the memory read, then two stages

	always_ff @(posedge clk) begin
		if (reset) begin
			raster_d <= '0;
			pel_ch   <= '0;
			pel_grid <= 1'b0;
			pel_win  <= 1'b0;
			color    <= '0;
		end else begin
			raster_d <= raster;
			pel_win  <= in_win;
			pel_ch   <= in_win ? hit : '0;
			pel_grid <= in_win && (row[4:0] == 5'd16);
			if (pel_ch[0])     color <= COLOR_A0;
			else if (pel_ch[1]) color <= COLOR_A1;
			else if (pel_ch[2]) color <= COLOR_B0;
			else if (pel_ch[3]) color <= COLOR_B1;
			else if (pel_grid)  color <= GD_COLOR;
			else if (pel_win)   color <= BG_COLOR;
			else                color <= '0;
		end
	end

	assign {red, green, blue} = color;

endmodule

`default_nettype wire

//--- verilog/tiny_scope_top.sv
////////////////////////////////////////////////////////////
// tiny strip-chart scope top level
// raster counter, accumulator, capture buffer, renderer
////////////////////////////////////////////////////////////

`default_nettype none

module tiny_scope_top #(
	parameter int              V_START  = 240,
	parameter int              V_HEIGHT = 192,
	parameter int              H_START  = 450,
	parameter int              H_END    = 750,
	parameter int              N_FRAMES = 3,
	// deep violet grid on near-black background
	parameter scope_pkg::rgb_t GD_COLOR = 24'h32006a,
	parameter scope_pkg::rgb_t BG_COLOR = 24'h1d1d1d
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   blank,
	input  logic                   vsync,
	input  scope_pkg::adc_sample_t sample,
	input  logic                   sample_valid,
	input  logic                   halt,
	output logic [7:0]             red,
	output logic [7:0]             green,
	output logic [7:0]             blue
);

	import scope_pkg::*;

	raster_t raster;
	column_t column;
	column_t rd_column;
	logic    commit;

	// decode
	raster_counter raster_counter_i (
		.clk    (clk),
		.reset  (reset),
		.blank  (blank),
		.vsync  (vsync),
		.raster (raster)
	);

	// execute
	minmax_accumulator #(
		.N_FRAMES (N_FRAMES)
	) minmax_accumulator_i (
		.clk          (clk),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.raster       (raster),
		.column       (column),
		.commit       (commit)
	);

	capture_buffer #(
		.H_START (H_START),
		.H_END   (H_END)
	) capture_buffer_i (
		.clk       (clk),
		.reset     (reset),
		.column    (column),
		.commit    (commit),
		.halt      (halt),
		.x         (raster.x),
		.rd_column (rd_column)
	);

	// result
	pixel_render #(
		.V_START  (V_START),
		.V_HEIGHT (V_HEIGHT),
		.H_START  (H_START),
		.H_END    (H_END),
		.GD_COLOR (GD_COLOR),
		.BG_COLOR (BG_COLOR)
	) pixel_render_i (
		.clk       (clk),
		.reset     (reset),
		.raster    (raster),
		.rd_column (rd_column),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

`default_nettype wire

//--- dv/tiny_scope_asserts.sv
////////////////////////////////////////////////////////////
// bound checks on the stage handshake of the scope
////////////////////////////////////////////////////////////

`default_nettype none

module tiny_scope_asserts (
	input logic       clk,
	input logic       reset,
	input logic       commit,
	input logic       frame_end,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);

	commit_single: assert property (@(posedge clk) disable iff (reset) commit |=> !commit)
		else $error("commit stayed high for more than one cycle");

	commit_after_frame_end: assert property (@(posedge clk) disable iff (reset)
		commit |-> $past(frame_end))
		else $error("commit without a frame end in the cycle before");

	black_in_reset: assert property (@(posedge clk) reset |=> ({red, green, blue} == 24'h0))
		else $error("outputs not black during reset");

endmodule

bind tiny_scope_top tiny_scope_asserts tiny_scope_asserts_i (
	.clk       (clk),
	.reset     (reset),
	.commit    (commit),
	.frame_end (raster.frame_end),
	.red       (red),
	.green     (green),
	.blue      (blue)
);

`default_nettype wire

//--- dv/tb_tiny_scope.sv
////////////////////////////////////////////////////////////
// testbench for the tiny strip-chart scope
// video timing, sample frames, probe table and checks
////////////////////////////////////////////////////////////

`default_nettype none

module tb_tiny_scope;

	import scope_pkg::*;

	localparam int   NUM_TESTS   = 14;
	localparam int   N_FRAMES    = 2;
	localparam int   VS_CYCLES   = 8;
	localparam int   H_BLANK     = 4;
	localparam int   H_ACTIVE    = 16;
	localparam int   LINES       = 70;
	localparam int   LINE_CYCLES = H_BLANK + H_ACTIVE;
	localparam int   FRAME_CYC   = VS_CYCLES + LINES * LINE_CYCLES;
	localparam int   TIMEOUT_CYC = NUM_TESTS * N_FRAMES * FRAME_CYC * 2;
	localparam rgb_t GD          = 24'h404080;
	localparam rgb_t BG          = 24'h101010;

	typedef struct packed {
		logic            valid;
		logic [3:0][7:0] lo;
		logic [3:0][7:0] hi;
	} frame_t;

	typedef struct packed {
		frame_t f0;
		frame_t f1;
		logic   halt;
		coord_t px;
		coord_t py;
		rgb_t   exp;
	} test_t;

	logic        clk;
	logic        reset;
	logic        blank;
	logic        vsync;
	adc_sample_t sample;
	logic        sample_valid;
	logic        halt;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;

	test_t  tests [NUM_TESTS];
	string  names [NUM_TESTS];
	int     n_tests;
	integer seed;
	int     pend_cnt;
	int     pend_idx;
	int     checks;
	int     value_errors;
	int     other_errors;
	int     cycles;

	tiny_scope_top #(
		.V_START  (4),
		.V_HEIGHT (64),
		.H_START  (4),
		.H_END    (11),
		.N_FRAMES (N_FRAMES),
		.GD_COLOR (GD),
		.BG_COLOR (BG)
	) tiny_scope_i (
		.clk          (clk),
		.reset        (reset),
		.blank        (blank),
		.vsync        (vsync),
		.sample       (sample),
		.sample_valid (sample_valid),
		.halt         (halt),
		.red          (red),
		.green        (green),
		.blue         (blue)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, the frames never completed", TIMEOUT_CYC);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic frame_t make_frame(input logic v, input int a0l, input int a0h,
			input int a1l, input int a1h, input int b0l, input int b0h,
			input int b1l, input int b1h);
		frame_t f;
		f.valid = v;
		f.lo = {8'(b1l), 8'(b0l), 8'(a1l), 8'(a0l)};
		f.hi = {8'(b1h), 8'(b0h), 8'(a1h), 8'(a0h)};
		return f;
	endfunction

	task automatic add_test(input string nm, input frame_t f0, input frame_t f1,
			input logic h, input int px, input int py, input rgb_t e);
		names[n_tests] = nm;
		tests[n_tests] = '{f0, f1, h, coord_t'(px), coord_t'(py), e};
		n_tests++;
	endtask

	////////////////////////////////////////////////////////////
	// probe table

	// parked channels sit at 200 and never light
	task automatic build_table();
		frame_t none;
		frame_t park;
		frame_t a0;
		frame_t a0a1;
		frame_t b0b1;
		frame_t spike;
		frame_t a1;
		none  = make_frame(1'b0, 0, 0, 0, 0, 0, 0, 0, 0);
		park  = make_frame(1'b1, 200, 200, 200, 200, 200, 200, 200, 200);
		a0    = make_frame(1'b1, 64, 72, 200, 200, 200, 200, 200, 200);
		a0a1  = make_frame(1'b1, 64, 72, 30, 40, 200, 200, 200, 200);
		b0b1  = make_frame(1'b1, 200, 200, 200, 200, 30, 40, 0, 5);
		spike = make_frame(1'b1, 64, 90, 200, 200, 200, 200, 200, 200);
		a1    = make_frame(1'b1, 200, 200, 30, 40, 200, 200, 200, 200);
		add_test("reset_bg", none, none, 1'b0, 8, 30, BG);
		add_test("a0_band", a0, a0, 1'b0, 11, 28, COLOR_A0);
		add_test("a0_below", a0, a0, 1'b0, 11, 19, BG);
		add_test("a0_above", a0, a0, 1'b0, 11, 29, BG);
		add_test("a0_over_a1", a0a1, a0a1, 1'b0, 11, 24, COLOR_A0);
		add_test("a1_only", a0a1, a0a1, 1'b0, 11, 18, COLOR_A1);
		add_test("b0_over_b1", b0b1, b0b1, 1'b0, 11, 54, COLOR_B0);
		add_test("grid", park, park, 1'b0, 11, 52, GD);
		add_test("spike", spike, a0, 1'b0, 11, 46, COLOR_A0);
		add_test("scroll", park, park, 1'b0, 10, 46, COLOR_A0);
		add_test("halt_blocks", a1, a1, 1'b1, 11, 18, BG);
		add_test("halt_freeze", park, park, 1'b1, 10, 46, COLOR_A0);
		add_test("empty", none, none, 1'b0, 11, 20, GD);
		add_test("outside_black", park, park, 1'b0, 13, 30, 24'h0);
	endtask

	task automatic check_probe();
		rgb_t act;
		act = {red, green, blue};
		checks++;
		if (act !== tests[pend_idx].exp) begin
			$display("ERR %s: expected %h, actual %h", names[pend_idx],
				tests[pend_idx].exp, act);
			value_errors++;
		end
	endtask

	// one cycle with inputs changed just after the edge
	task automatic step();
		@(posedge clk);
		#1;
		if (pend_cnt > 0) begin
			pend_cnt--;
			if (pend_cnt == 0) check_probe();
		end
	endtask

	task automatic draw_sample(input frame_t f, input int n);
		adc_value_t v [NUM_CHANNELS];
		int         span;
		int         r;
		int         nib;
		logic [7:0] t;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			span = int'(f.hi[k]) - int'(f.lo[k]) + 1;
			r    = $random(seed);
			nib  = $random(seed);
			// extremes come first so the span is exact
			if (n == 0) t = f.lo[k];
			else if (n == 1) t = f.hi[k];
			else t = 8'(int'(f.lo[k]) + ((r & 32'h7fffffff) % span));
			v[k] = {t, 4'(nib)};
		end
		sample = {v[0], v[1], v[2], v[3]};
	endtask

	task automatic run_frame(input frame_t f, input int probe, input logic halt_v);
		int n;
		n = 0;
		for (int c = 0; c < VS_CYCLES; c++) begin
			step();
			halt         = halt_v;
			vsync        = 1'b1;
			blank        = 1'b1;
			sample_valid = 1'b0;
		end
		for (int ln = 0; ln < LINES; ln++) begin
			for (int c = 0; c < LINE_CYCLES; c++) begin
				step();
				vsync        = 1'b0;
				blank        = (c < H_BLANK);
				sample_valid = 1'b0;
				if (c >= H_BLANK) begin
					if (f.valid) begin
						draw_sample(f, n);
						sample_valid = 1'b1;
						n++;
					end
					if (probe >= 0 && c - H_BLANK == int'(tests[probe].px) &&
							ln == int'(tests[probe].py)) begin
						pend_idx = probe;
						pend_cnt = 4;
					end
				end
			end
		end
	endtask

	initial begin
		reset        = 1'b1;
		blank        = 1'b1;
		vsync        = 1'b0;
		sample       = '0;
		sample_valid = 1'b0;
		halt         = 1'b0;
		seed         = 32'hae5e;
		n_tests      = 0;
		pend_cnt     = 0;
		pend_idx     = 0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		cycles       = 0;
		build_table();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		// first frame probes before any commit
		run_frame(tests[0].f0, 0, 1'b0);
		for (int i = 1; i < NUM_TESTS; i++) begin
			if (i >= 2) run_frame(tests[i].f0, i - 1, tests[i - 1].halt);
			else run_frame(tests[i].f0, -1, 1'b0);
			run_frame(tests[i].f1, -1, 1'b0);
		end
		run_frame(tests[0].f0, NUM_TESTS - 1, tests[NUM_TESTS - 1].halt);
		repeat (6) step();
		if (checks != NUM_TESTS) begin
			$display("only %0d of %0d probe pixels were reached", checks, NUM_TESTS);
			other_errors++;
		end
		$display("errors: %0d value, %0d other, %0d checks", value_errors, other_errors,
			checks);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/scope_pkg.sv
verilog/raster_counter.sv
verilog/minmax_accumulator.sv
verilog/capture_buffer.sv
verilog/pixel_render.sv
verilog/tiny_scope_top.sv
dv/tiny_scope_asserts.sv
dv/tb_tiny_scope.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tiny_scope
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(BUILD_DIR)
